/* cpu16.f */
+incdir+common
common/cpu_isa_pkg.sv
common/cpu_dp_pkg.sv
hdl/reg_file.sv
hdl/alu.sv
hdl/memory.sv
controller/controller.sv
hdl/cpu_top.sv
tests/cpu_tb.sv

/* tests/cpu_tb.sv */
`timescale 1ns/10ps

module cpu_tb;

  localparam int CLK_PERIOD  = 8;
  localparam int NUM_PROG    = 7;
  localparam int PROG_WORDS  = 16;
  localparam int TAIL_CYCLES = 20;
  localparam int WATCHDOG_NS = NUM_PROG * 40 * 7 * CLK_PERIOD;

  logic        clk = 1'b0;
  logic        rst_n;
  logic        load_en;
  logic [7:0]  load_addr;
  logic [15:0] load_data;
  logic [15:0] dsp_data;
  logic        dsp_valid;
  logic        halted;

  // Program table, word 0 of each program sits at the left
  logic [0:PROG_WORDS-1][15:0] prog_words [NUM_PROG];
  logic [0:3][15:0]            prog_outs  [NUM_PROG];
  int                          prog_nout  [NUM_PROG];
  int                          prog_len   [NUM_PROG]; // Instructions executed up to HLT

  int          cycles;
  int          got_n;
  logic [15:0] got_out [8];

  cpu_top u_cpu_top (
    .clk(clk),
    .rst_n(rst_n),
    .load_en(load_en),
    .load_addr(load_addr),
    .load_data(load_data),
    .dsp_data(dsp_data),
    .dsp_valid(dsp_valid),
    .halted(halted)
  );

  always #(CLK_PERIOD / 2) clk = ~clk;

  task automatic check_eq(input string name, input logic [31:0] got,
                          input logic [31:0] expected);
    if (got !== expected) begin
      $display("Error at %0d ns: %s got 0x%0h expected 0x%0h", $time, name, got, expected);
      $display("tests failed");
      $fatal(1, "mismatch on %s", name);
    end
  endtask

  task automatic build_table();
    // LLI and LUI constants, direct OUT and OUT of memory word 12
    prog_words[0] = {128'h1534_2512_0250_160C_0360_27AB_17CD_0270,
                     128'h0F00_0000_0000_0000_BEEF_0000_0000_0000};
    prog_outs[0]  = 64'h1234_BEEF_ABCD_0000;
    prog_nout[0]  = 3;
    prog_len[0]   = 9;
    // ADD wraps, SUB immediate borrows, SHL by low 4 bits, OR indirect
    prog_words[1] = {128'h15FF_25FF_1602_4056_4663_0250_0260_1781,
                     128'h1813_5478_190E_4D79_0270_0F00_1000_0000};
    prog_outs[1]  = 64'h0001_FFFF_1408_0000;
    prog_nout[1]  = 3;
    prog_len[1]   = 14;
    // XOR register, SHR and AND immediate
    prog_words[2] = {128'h15F0_25A5_163C_5056_0250_5A54_0250_4A6A,
                     128'h0260_0F00_0000_0000_0000_0000_0000_0000};
    prog_outs[2]  = 64'hA5CC_0A5C_0008_0000;
    prog_nout[2]  = 3;
    prog_len[2]   = 10;
    // ST* and LD* through address 14, then LD and ST copies
    prog_words[3] = {128'h155A_25C3_160C_4262_3356_3276_0270_3086,
                     128'h0280_1A77_31A9_0290_0F00_0000_0000_0000};
    prog_outs[3]  = 64'hC35A_000E_0077_0000;
    prog_nout[3]  = 3;
    prog_len[3]   = 13;
    // Equal compare, NZ N C fall through and NV jumps to word 12
    prog_words[4] = {128'h130C_1711_1822_9177_0270_9277_0270_9477,
                     128'h0270_9777_0270_0F00_0280_0F00_0000_0000};
    prog_outs[4]  = 64'h0011_0011_0011_0022;
    prog_nout[4]  = 4;
    prog_len[4]   = 12;
    // 3 - 5 leaves Z NN NC untaken, 0x8000 - 0x11 overflows into word 14
    prog_words[5] = {128'h130E_1711_1822_1903_1A05_2B80_909A_0270,
                     128'h939A_0270_959A_0270_96B7_0F00_0280_0F00};
    prog_outs[5]  = 64'h0011_0011_0011_0022;
    prog_nout[5]  = 4;
    prog_len[5]   = 15;
    // Call to word 13 and back, two pushes popped in reverse, SP back at 0
    prog_words[6] = {128'h150D_8045_0260_1771_1882_A070_A080_A190,
                     128'hA1A0_0290_02A0_0220_0F00_1666_8004_0000};
    prog_outs[6]  = 64'h0066_0082_0071_0000;
    prog_nout[6]  = 4;
    prog_len[6]   = 15;
  endtask

  task automatic reset_dut();
    @(negedge clk);
    rst_n   = 1'b0;
    load_en = 1'b1; // Keeps the CPU held once reset ends
    repeat (3) @(negedge clk);
    rst_n = 1'b1;
  endtask

  task automatic load_program(input int k);
    for (int i = 0; i < PROG_WORDS; i++) begin
      load_addr = 8'(i);
      load_data = prog_words[k][i];
      @(negedge clk);
    end
    load_en = 1'b0;
  endtask

  // Counts cycles from release until halted and records each display word
  task automatic run_program();
    cycles = 0;
    got_n  = 0;
    while (halted !== 1'b1) begin
      @(negedge clk);
      cycles++;
      if (dsp_valid === 1'b1) begin
        if (got_n < 8) begin
          got_out[got_n] = dsp_data;
        end
        got_n++;
      end
    end
  endtask

  task automatic check_program(input int k);
    check_eq($sformatf("prog %0d dsp_valid count", k), got_n, prog_nout[k]);
    for (int i = 0; i < prog_nout[k]; i++) begin
      check_eq($sformatf("prog %0d dsp_data[%0d]", k, i), got_out[i], prog_outs[k][i]);
    end
    // HLT raises halted at its step 3
    check_eq($sformatf("prog %0d cycles to halted", k), cycles, 7 * prog_len[k] - 3);
  endtask

  task automatic check_after_halt(input int k);
    repeat (TAIL_CYCLES) begin
      @(negedge clk);
      check_eq($sformatf("prog %0d halted", k), halted, 1);
      check_eq($sformatf("prog %0d dsp_valid", k), dsp_valid, 0);
    end
  endtask

  initial begin
    rst_n     = 1'b0;
    load_en   = 1'b1;
    load_addr = '0;
    load_data = '0;
    build_table();
    for (int k = 0; k < NUM_PROG; k++) begin
      reset_dut();
      load_program(k);
      run_program();
      check_program(k);
      check_after_halt(k);
    end
    $display("all tests passed");
    $finish;
  end

  initial begin
    #(WATCHDOG_NS);
    $display("The CPU never halted within %0d ns", WATCHDOG_NS);
    $display("tests failed");
    $fatal(1, "watchdog expired");
  end

endmodule

/* hdl/cpu_top.sv */
`timescale 1ns/10ps
`include "cpu16_consts.svh"

module cpu_top
  import cpu_isa_pkg::*;
  import cpu_dp_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   load_en,
  input  logic [7:0]             load_addr,
  input  logic [`CPU_WORD_W-1:0] load_data,
  output logic [`CPU_WORD_W-1:0] dsp_data,
  output logic                   dsp_valid,
  output logic                   halted
);

  logic [`CPU_WORD_W-1:0] bus;
  logic [`CPU_WORD_W-1:0] src_val;
  logic [`CPU_WORD_W-1:0] dst_val;
  logic [`CPU_WORD_W-1:0] alu_result;
  logic [`CPU_WORD_W-1:0] mem_rdata;
  logic [`CPU_WORD_W-1:0] imm_val;
  logic [FLAG_W-1:0]      flags;
  alu_op_t                alu_op;
  reg_idx_t               reg_src_sel;
  reg_idx_t               reg_dst_sel;
  logic                   alu_out_en;
  logic                   mem_addr_en;
  logic                   mem_in_en;
  logic                   mem_out_en;
  logic                   reg_in_en;
  logic                   reg_up_en;
  logic                   reg_lo_en;
  logic                   reg_pc_inc;
  logic                   reg_sp_inc;
  logic                   reg_sp_dec;
  logic                   reg_out_en;
  logic                   ctl_out_en;
  logic                   dsp_in_en;

  // Zero when nobody drives
  assign bus = ({`CPU_WORD_W{reg_out_en}} & src_val)
             | ({`CPU_WORD_W{alu_out_en}} & alu_result)
             | ({`CPU_WORD_W{mem_out_en}} & mem_rdata)
             | ({`CPU_WORD_W{ctl_out_en}} & imm_val);

  assign dsp_data  = bus;
  assign dsp_valid = dsp_in_en;

  controller u_controller (
    .clk(clk), .rst_n(rst_n), .hold(load_en), .bus(bus), .flags(flags),
    .alu_op(alu_op), .reg_src_sel(reg_src_sel), .reg_dst_sel(reg_dst_sel),
    .alu_out_en(alu_out_en), .mem_addr_en(mem_addr_en), .mem_in_en(mem_in_en),
    .mem_out_en(mem_out_en), .reg_in_en(reg_in_en), .reg_up_en(reg_up_en),
    .reg_lo_en(reg_lo_en), .reg_pc_inc(reg_pc_inc), .reg_sp_inc(reg_sp_inc),
    .reg_sp_dec(reg_sp_dec), .reg_out_en(reg_out_en), .ctl_out_en(ctl_out_en),
    .dsp_in_en(dsp_in_en), .halted(halted), .imm_val(imm_val)
  );

  reg_file u_reg_file (
    .clk(clk), .rst_n(rst_n), .src_sel(reg_src_sel), .dst_sel(reg_dst_sel),
    .bus(bus), .in_en(reg_in_en), .up_en(reg_up_en), .lo_en(reg_lo_en),
    .pc_inc(reg_pc_inc), .sp_inc(reg_sp_inc), .sp_dec(reg_sp_dec),
    .src_val(src_val), .dst_val(dst_val)
  );

  alu u_alu (
    .clk(clk), .rst_n(rst_n), .op(alu_op), .a(dst_val), .b(src_val),
    .latch(alu_out_en), .result(alu_result), .flags(flags)
  );

  memory u_memory (
    .clk(clk), .rst_n(rst_n), .bus(bus), .addr_en(mem_addr_en), .in_en(mem_in_en),
    .load_en(load_en), .load_addr(load_addr), .load_data(load_data), .rdata(mem_rdata)
  );

endmodule

/* controller/controller.sv */
`timescale 1ns/10ps
`include "cpu16_consts.svh"

module controller
  import cpu_isa_pkg::*;
  import cpu_dp_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic                   hold,
  input  logic [`CPU_WORD_W-1:0] bus,
  input  logic [FLAG_W-1:0]      flags,
  output alu_op_t                alu_op,
  output reg_idx_t               reg_src_sel,
  output reg_idx_t               reg_dst_sel,
  output logic                   alu_out_en,
  output logic                   mem_addr_en,
  output logic                   mem_in_en,
  output logic                   mem_out_en,
  output logic                   reg_in_en,
  output logic                   reg_up_en,
  output logic                   reg_lo_en,
  output logic                   reg_pc_inc,
  output logic                   reg_sp_inc,
  output logic                   reg_sp_dec,
  output logic                   reg_out_en,
  output logic                   ctl_out_en,
  output logic                   dsp_in_en,
  output logic                   halted,
  output logic [`CPU_WORD_W-1:0] imm_val
);

  logic [2:0]             step;
  logic [`CPU_WORD_W-1:0] inst;
  opcode_t                opcode;
  logic [3:0]             funct;
  reg_idx_t               dst;
  reg_idx_t               src;
  alu_op_t                alu_funct;
  logic                   imm;
  logic                   ind;
  logic                   out_op;

  function automatic logic br_taken(input logic [3:0] cond, input logic [FLAG_W-1:0] f);
    case (cond)
      BR_Z:    return f[FLAG_Z];
      BR_NZ:   return !f[FLAG_Z];
      BR_N:    return f[FLAG_N];
      BR_NN:   return !f[FLAG_N];
      BR_C:    return f[FLAG_C];
      BR_NC:   return !f[FLAG_C];
      BR_V:    return f[FLAG_V];
      BR_NV:   return !f[FLAG_V];
      default: return 1'b0;
    endcase
  endfunction

  assign opcode    = opcode_t'(inst[15:12]);
  assign funct     = inst[11:8];
  assign dst       = inst[7:4];
  assign src       = inst[3:0];
  assign alu_funct = alu_op_t'(inst[13:10]);
  assign imm       = inst[9];
  assign ind       = inst[8];

  // Funct 3 is OUT with bit 8 set, shows the memory word instead
  assign out_op = (opcode == OP_SYS) && ({funct[3:1], 1'b0} == SYS_OUT);

  // ALU groups carry a 4 bit immediate
  assign imm_val = (inst[15:14] == 2'b01) ? {{(`CPU_WORD_W-4){1'b0}}, inst[3:0]}
                                          : {{(`CPU_WORD_W-8){1'b0}}, inst[7:0]};

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      step <= '0;
    end else if (hold) begin
      step <= '0;
    end else if (!halted) begin
      step <= (step == `CPU_STEP_LAST) ? 3'd0 : step + 3'd1;
    end
  end

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      inst   <= '0;
      halted <= 1'b0;
    end else if (!hold && !halted) begin
      if (step == 3'd0)
        inst <= '0;
      if (step == 3'd2)
        inst <= bus; // Memory word is on the bus now
      if (step == 3'd3 && opcode == OP_SYS && funct == SYS_HLT)
        halted <= 1'b1;
    end
  end

  // Strobes decided here are live one cycle later
  always_ff @(posedge clk) begin
    alu_op      <= ALU_ADD;
    reg_src_sel <= '0;
    reg_dst_sel <= '0;
    alu_out_en  <= 1'b0;
    mem_addr_en <= 1'b0;
    mem_in_en   <= 1'b0;
    mem_out_en  <= 1'b0;
    reg_in_en   <= 1'b0;
    reg_up_en   <= 1'b0;
    reg_lo_en   <= 1'b0;
    reg_pc_inc  <= 1'b0;
    reg_sp_inc  <= 1'b0;
    reg_sp_dec  <= 1'b0;
    reg_out_en  <= 1'b0;
    ctl_out_en  <= 1'b0;
    dsp_in_en   <= 1'b0;
    if (rst_n && !hold && !halted) begin
      case (step)
        3'd0: begin
          reg_src_sel <= REG_PC;
          reg_out_en  <= 1'b1;
          mem_addr_en <= 1'b1;
        end
        3'd1: begin
          mem_out_en <= 1'b1;
          reg_pc_inc <= 1'b1;
        end
        3'd2: begin
        end
        default: begin
          case (opcode)
            OP_SYS: begin
              if (out_op && step == 3'd3) begin
                reg_src_sel <= dst;
                reg_out_en  <= 1'b1;
                mem_addr_en <= ind;
                dsp_in_en   <= !ind;
              end else if (out_op && ind && step == 3'd4) begin
                mem_out_en <= 1'b1;
                dsp_in_en  <= 1'b1;
              end
            end
            OP_LLI, OP_LUI: begin
              if (step == 3'd3) begin
                reg_dst_sel <= funct; // Target register sits in funct
                ctl_out_en  <= 1'b1;
                reg_lo_en   <= (opcode == OP_LLI);
                reg_up_en   <= (opcode == OP_LUI);
              end
            end
            OP_MEM: begin
              case (funct)
                MEM_LD, MEM_ST: begin
                  if (step == 3'd3) begin
                    reg_src_sel <= (funct == MEM_LD) ? src : dst;
                    reg_dst_sel <= (funct == MEM_LD) ? dst : src;
                    reg_out_en  <= 1'b1;
                    reg_in_en   <= 1'b1;
                  end
                end
                MEM_LDI, MEM_STI: begin
                  if (step == 3'd3) begin
                    reg_src_sel <= src;
                    reg_out_en  <= 1'b1;
                    mem_addr_en <= 1'b1;
                  end else if (step == 3'd4 && funct == MEM_LDI) begin
                    reg_dst_sel <= dst;
                    mem_out_en  <= 1'b1;
                    reg_in_en   <= 1'b1;
                  end else if (step == 3'd4) begin
                    reg_src_sel <= dst;
                    reg_out_en  <= 1'b1;
                    mem_in_en   <= 1'b1;
                  end
                end
                default: begin
                end
              endcase
            end
            OP_ALU0, OP_ALU1, OP_ALU2, OP_ALU3: begin
              alu_op <= alu_funct;
              if (imm) begin
                if (step == 3'd3) begin
                  reg_dst_sel <= REG_RES;
                  ctl_out_en  <= 1'b1;
                  reg_in_en   <= 1'b1;
                end else if (step == 3'd4) begin
                  reg_src_sel <= REG_RES;
                  reg_dst_sel <= dst;
                  alu_out_en  <= 1'b1;
                  reg_in_en   <= 1'b1;
                end
              end else if (ind) begin
                if (step == 3'd3) begin
                  reg_src_sel <= src;
                  reg_out_en  <= 1'b1;
                  mem_addr_en <= 1'b1;
                end else if (step == 3'd4) begin
                  reg_dst_sel <= REG_RES;
                  mem_out_en  <= 1'b1;
                  reg_in_en   <= 1'b1;
                end else if (step == 3'd5) begin
                  reg_src_sel <= REG_RES;
                  reg_dst_sel <= dst;
                  alu_out_en  <= 1'b1;
                  reg_in_en   <= 1'b1;
                end
              end else if (step == 3'd3) begin
                reg_src_sel <= src;
                reg_dst_sel <= dst;
                alu_out_en  <= 1'b1;
                reg_in_en   <= 1'b1;
              end
            end
            OP_JALR: begin
              if (step == 3'd3) begin
                reg_src_sel <= REG_PC; // Link first
                reg_dst_sel <= dst;
                reg_out_en  <= 1'b1;
                reg_in_en   <= 1'b1;
              end else if (step == 3'd4) begin
                reg_src_sel <= src;
                reg_dst_sel <= REG_PC;
                reg_out_en  <= 1'b1;
                reg_in_en   <= 1'b1;
              end
            end
            OP_BR: begin
              if (step == 3'd3) begin
                reg_src_sel <= src;
                reg_dst_sel <= dst;
                alu_op      <= ALU_SUB;
                alu_out_en  <= 1'b1;
              end else if (step == 3'd5 && br_taken(funct, flags)) begin
                // Flags from the compare are visible from step 5 on
                reg_src_sel <= REG_BA;
                reg_dst_sel <= REG_PC;
                reg_out_en  <= 1'b1;
                reg_in_en   <= 1'b1;
              end
            end
            OP_STK: begin
              case (funct)
                STK_PUSH: begin
                  if (step == 3'd3) begin
                    reg_sp_dec <= 1'b1; // Pre-decrement
                  end else if (step == 3'd4) begin
                    reg_src_sel <= REG_SP;
                    reg_out_en  <= 1'b1;
                    mem_addr_en <= 1'b1;
                  end else if (step == 3'd5) begin
                    reg_src_sel <= dst;
                    reg_out_en  <= 1'b1;
                    mem_in_en   <= 1'b1;
                  end
                end
                STK_POP: begin
                  if (step == 3'd3) begin
                    reg_src_sel <= REG_SP;
                    reg_out_en  <= 1'b1;
                    mem_addr_en <= 1'b1;
                  end else if (step == 3'd4) begin
                    reg_dst_sel <= dst;
                    mem_out_en  <= 1'b1;
                    reg_in_en   <= 1'b1;
                  end else if (step == 3'd5) begin
                    reg_sp_inc <= 1'b1;
                  end
                end
                default: begin
                end
              endcase
            end
            default: begin
            end
          endcase
        end
      endcase
    end
  end

  step_in_range: assert property (@(posedge clk) disable iff (!rst_n)
    step <= `CPU_STEP_LAST)
    else $error("step counter out of range");

  one_bus_driver: assert property (@(posedge clk) disable iff (!rst_n)
    $onehot0({alu_out_en, mem_out_en, reg_out_en, ctl_out_en}))
    else $error("more than one bus driver");

endmodule

/* hdl/memory.sv */
`timescale 1ns/10ps
`include "cpu16_consts.svh"

module memory (
  input  logic                   clk,
  input  logic                   rst_n,
  input  logic [`CPU_WORD_W-1:0] bus,
  input  logic                   addr_en,
  input  logic                   in_en,
  input  logic                   load_en,
  input  logic [7:0]             load_addr,
  input  logic [`CPU_WORD_W-1:0] load_data,
  output logic [`CPU_WORD_W-1:0] rdata
);

  logic [7:0]             addr;
  logic [`CPU_WORD_W-1:0] ram [`CPU_MEM_DEPTH];

  always_ff @(posedge clk) begin
    if (!rst_n)
      addr <= '0;
    else if (addr_en)
      addr <= bus[7:0];
  end

  always_ff @(posedge clk) begin
    if (load_en)
      ram[load_addr] <= load_data; // Program loader
    else if (in_en)
      ram[addr] <= bus;
  end

  // Readable the cycle after the address is latched
  assign rdata = ram[addr];

endmodule

/* hdl/alu.sv */
`timescale 1ns/10ps
`include "cpu16_consts.svh"

module alu
  import cpu_dp_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  alu_op_t                op,
  input  logic [`CPU_WORD_W-1:0] a,
  input  logic [`CPU_WORD_W-1:0] b,
  input  logic                   latch,
  output logic [`CPU_WORD_W-1:0] result,
  output logic [FLAG_W-1:0]      flags
);

  localparam int MSB = `CPU_WORD_W - 1;

  logic [`CPU_WORD_W:0] wide; // Carry out in the top bit
  logic [`CPU_WORD_W:0] shr_tmp;
  logic                 ovf;

  always_comb begin
    wide    = '0;
    ovf     = 1'b0;
    shr_tmp = {a, 1'b0} >> b[3:0]; // Last bit out lands in bit 0
    case (op)
      ALU_ADD: begin
        wide = {1'b0, a} + {1'b0, b};
        ovf  = (a[MSB] == b[MSB]) && (wide[MSB] != a[MSB]);
      end
      ALU_SUB: begin
        wide = {1'b0, a} - {1'b0, b};
        ovf  = (a[MSB] != b[MSB]) && (wide[MSB] != a[MSB]);
      end
      ALU_AND: wide = {1'b0, a & b};
      ALU_OR:  wide = {1'b0, a | b};
      ALU_XOR: wide = {1'b0, a ^ b};
      ALU_SHL: wide = {1'b0, a} << b[3:0];
      ALU_SHR: wide = {shr_tmp[0], shr_tmp[`CPU_WORD_W:1]};
      default: wide = '0;
    endcase
  end

  assign result = wide[MSB:0];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      flags <= '0;
    end else if (latch) begin
      flags[FLAG_Z] <= (result == '0);
      flags[FLAG_N] <= result[MSB];
      flags[FLAG_C] <= wide[`CPU_WORD_W];
      flags[FLAG_V] <= ovf;
    end
  end

endmodule

/* hdl/reg_file.sv */
`timescale 1ns/10ps
`include "cpu16_consts.svh"

module reg_file
  import cpu_isa_pkg::*;
(
  input  logic                   clk,
  input  logic                   rst_n,
  input  reg_idx_t               src_sel,
  input  reg_idx_t               dst_sel,
  input  logic [`CPU_WORD_W-1:0] bus,
  input  logic                   in_en,
  input  logic                   up_en,
  input  logic                   lo_en,
  input  logic                   pc_inc,
  input  logic                   sp_inc,
  input  logic                   sp_dec,
  output logic [`CPU_WORD_W-1:0] src_val,
  output logic [`CPU_WORD_W-1:0] dst_val
);

  logic [`CPU_WORD_W-1:0] regs [`CPU_REG_N];

  always_ff @(posedge clk) begin
    if (!rst_n) begin
      for (int i = 0; i < `CPU_REG_N; i++) begin
        regs[i] <= '0;
      end
    end else begin
      if (pc_inc)
        regs[REG_PC] <= regs[REG_PC] + 1'b1;
      if (sp_inc)
        regs[REG_SP] <= regs[REG_SP] + 1'b1;
      if (sp_dec)
        regs[REG_SP] <= regs[REG_SP] - 1'b1;
      // Bus writes win over the in-place counters
      if (in_en)
        regs[dst_sel] <= bus;
      if (lo_en)
        regs[dst_sel][7:0] <= bus[7:0];
      if (up_en)
        regs[dst_sel][`CPU_WORD_W-1:8] <= bus[7:0]; // Byte comes in on the low lane
    end
  end

  assign src_val = regs[src_sel];
  assign dst_val = regs[dst_sel];

  sp_step_excl: assert property (@(posedge clk) disable iff (!rst_n)
    !(sp_inc && sp_dec))
    else $error("SP stepped both ways at once");

endmodule

/* common/cpu_dp_pkg.sv */
package cpu_dp_pkg;

  typedef enum logic [3:0] {
    ALU_ADD = 4'd0,
    ALU_SUB = 4'd1,
    ALU_AND = 4'd2,
    ALU_OR  = 4'd3,
    ALU_XOR = 4'd4,
    ALU_SHL = 4'd5, // Amount from low 4 bits of b
    ALU_SHR = 4'd6
  } alu_op_t;

  localparam int FLAG_W = 4;

  localparam int FLAG_Z = 0;
  localparam int FLAG_N = 1;
  localparam int FLAG_C = 2; // Borrow on SUB
  localparam int FLAG_V = 3;

endpackage

/* common/cpu_isa_pkg.sv */
package cpu_isa_pkg;

  typedef enum logic [3:0] {
    OP_SYS  = 4'd0,
    OP_LLI  = 4'd1,
    OP_LUI  = 4'd2,
    OP_MEM  = 4'd3,
    OP_ALU0 = 4'd4,
    OP_ALU1 = 4'd5,
    OP_ALU2 = 4'd6,
    OP_ALU3 = 4'd7,
    OP_JALR = 4'd8,
    OP_BR   = 4'd9,
    OP_STK  = 4'd10
  } opcode_t;

  typedef enum logic [3:0] {SYS_NOP = 4'd0, SYS_OUT = 4'd2, SYS_HLT = 4'd15} sys_funct_t;

  typedef enum logic [3:0] {MEM_LD = 4'd0, MEM_ST = 4'd1, MEM_LDI = 4'd2, MEM_STI = 4'd3} mem_funct_t;

  typedef enum logic [3:0] {STK_PUSH = 4'd0, STK_POP = 4'd1} stk_funct_t;

  typedef enum logic [3:0] {
    BR_Z  = 4'd0,
    BR_NZ = 4'd1,
    BR_N  = 4'd2,
    BR_NN = 4'd3,
    BR_C  = 4'd4,
    BR_NC = 4'd5,
    BR_V  = 4'd6,
    BR_NV = 4'd7
  } br_cond_t;

  typedef logic [3:0] reg_idx_t;

  localparam reg_idx_t REG_PC  = 4'd1;
  localparam reg_idx_t REG_SP  = 4'd2;
  localparam reg_idx_t REG_BA  = 4'd3; // Branch target
  localparam reg_idx_t REG_RA  = 4'd4; // Return address by convention
  localparam reg_idx_t REG_RES = 4'd15; // Scratch for immediate and indirect operands

endpackage

/* common/cpu16_consts.svh */
`ifndef CPU16_CONSTS_SVH
`define CPU16_CONSTS_SVH

`define CPU_WORD_W 16
`define CPU_REG_N 16

// Addressed by the low 8 bits of the bus
`define CPU_MEM_DEPTH 256

`define CPU_STEP_LAST 6

`endif
